/* compile.f */
+incdir+verilog
verilog/synctimer_pkg.sv
verilog/synctimer_timer.sv
verilog/sync_interval_counter.sv
verilog/sync_frame_fsm.sv
verilog/sync_frame_shifter.sv
verilog/synctimer_master.sv
verification/synctimer_master_tb.sv

/* Makefile */
# Verilator build and run for the sync timer master

TOP := synctimer_master_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f compile.f --Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

/* verification/synctimer_master_tb.sv */
`timescale 1ns/1ps
`include "synctimer_macros.svh"

module synctimer_master_tb;

    import synctimer_pkg::*;

    localparam int LAST_IDX = `SYNC_FRAME_BYTES - 1;

    logic       clk;
    logic       reset;
    sync_time_t set_time;
    logic       set_valid;
    logic       adjust_sign;
    logic       adjust_valid;
    logic       adjust_ready;
    sync_time_t current_time;
    logic       start;
    logic       override;
    logic       sync_enable;
    sync_byte_t m_stream;
    logic       m_valid;
    logic       m_ready;

    // reference model state as of the last edge
    sync_time_t  m_base;      // last loaded time
    logic [63:0] m_k;         // cycles since reset or load
    sync_time_t  m_adj;       // net adjust mod 2^64
    logic        m_adj_ready;
    logic        m_busy;
    int          m_idx;
    logic [7:0]  exp_bytes [`SYNC_FRAME_BYTES];
    int          m_count;
    logic        m_tick;

    logic        ready_random;
    int          cycle_no;

    synctimer_master DUT (
        .clk          (clk),
        .reset        (reset),
        .set_time     (set_time),
        .set_valid    (set_valid),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready),
        .current_time (current_time),
        .start        (start),
        .override     (override),
        .sync_enable  (sync_enable),
        .m_stream     (m_stream),
        .m_valid      (m_valid),
        .m_ready      (m_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // floor(k*N/D) on top of the loaded value
    function automatic sync_time_t model_time();
        return m_base + (m_k * 64'(`SYNC_NUMERATOR)) / 64'(`SYNC_DENOMINATOR) + m_adj;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%h, expected 0x%h at cycle %0d",
                     name, actual, expected, cycle_no);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Done: errors found");
        $fatal(1, "wait loop ran out of cycles");
    endtask

    task automatic init_model();
        m_base      = '0;
        m_k         = '0;
        m_adj       = '0;
        m_adj_ready = 1'b1;
        m_busy      = 1'b0;
        m_idx       = 0;
        m_count     = 0;
        m_tick      = 1'b0;
    endtask

    // expected bytes in wire order
    task automatic capture_frame(input sync_time_t now);
        logic [15:0] ofs;
        ofs = `SYNC_OFFSET;
        exp_bytes[0] = `SYNC_NODE_ID;
        exp_bytes[1] = override ? 8'h10 : 8'h11;
        for (int i = 0; i < 8; i++) begin
            exp_bytes[2 + i] = now[8 * i +: 8];
        end
        exp_bytes[10] = ofs[7:0];
        exp_bytes[11] = ofs[15:8];
    endtask

    // effect of the coming rising edge on the model
    task automatic update_model();
        sync_time_t now;
        logic       accept;
        now    = model_time();
        accept = adjust_valid && m_adj_ready && !set_valid;
        if (!m_busy) begin
            if (start || m_tick) begin
                capture_frame(now);
                m_busy = 1'b1;
                m_idx  = 0;
            end
        end else if (m_ready) begin
            if (m_idx == LAST_IDX) begin
                m_busy = 1'b0;
            end else begin
                m_idx++;
            end
        end
        m_tick = sync_enable && (m_count == `SYNC_INTERVAL - 1);
        if (!sync_enable || m_count == `SYNC_INTERVAL - 1) begin
            m_count = 0;
        end else begin
            m_count++;
        end
        if (set_valid) begin
            m_base = set_time; // set wins over adjust
            m_k    = '0;
            m_adj  = '0;
        end else begin
            m_k++;
            if (accept) begin
                m_adj = adjust_sign ? m_adj - 64'd1 : m_adj + 64'd1;
            end
        end
        m_adj_ready = !accept;
    endtask

    task automatic compare_outputs();
        check_value("current_time", current_time, model_time());
        check_value("adjust_ready", adjust_ready, m_adj_ready);
        check_value("m_valid", m_valid, m_busy);
        check_value("m_stream.last", m_stream.last, m_busy && (m_idx == LAST_IDX));
        if (m_busy) begin
            check_value("m_stream.data", m_stream.data, exp_bytes[m_idx]);
        end
    endtask

    task automatic advance();
        update_model();
        @(negedge clk);
        cycle_no++;
        start        = 1'b0;
        set_valid    = 1'b0;
        adjust_valid = 1'b0;
        compare_outputs();
        if (ready_random) begin
            m_ready = 1'($urandom % 2);
        end
    endtask

    // caller raises start first
    task automatic receive_frame(input logic extra_starts);
        int waited;
        int bytes;
        waited = 0;
        bytes  = 0;
        advance(); // trigger edge
        while (m_valid) begin
            if (m_ready) begin
                bytes++;
            end
            if (extra_starts) begin
                start = ($urandom % 4) == 0; // should be dropped
            end
            advance();
            waited++;
            if (waited > 20 * `SYNC_FRAME_BYTES) begin
                fail_timeout("the end of a sync frame");
            end
        end
        check_value("bytes per frame", bytes, `SYNC_FRAME_BYTES);
    endtask

    initial begin
        int   r;
        int   frames;
        int   last_start;
        logic prev_valid;

        void'($urandom(32'h6357));
        reset        = 1'b1;
        set_time     = '0;
        set_valid    = 1'b0;
        adjust_sign  = 1'b0;
        adjust_valid = 1'b0;
        start        = 1'b0;
        override     = 1'b0;
        sync_enable  = 1'b0;
        m_ready      = 1'b1;
        ready_random = 1'b0;
        cycle_no     = 0;
        init_model();

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // free-running rate
        for (int k = 1; k <= 300; k++) begin
            advance();
            check_value("current_time", current_time,
                        (64'(k) * `SYNC_NUMERATOR) / `SYNC_DENOMINATOR);
        end

        // random loads and adjusts
        for (int i = 0; i < 400; i++) begin
            r = $urandom % 8;
            if (r == 0) begin
                set_time     = {$urandom, $urandom};
                set_valid    = 1'b1;
                adjust_valid = adjust_ready && (($urandom % 2) == 1);
                adjust_sign  = 1'($urandom % 2);
            end else if (r < 4 && adjust_ready) begin
                adjust_valid = 1'b1;
                adjust_sign  = 1'($urandom % 2);
            end
            advance();
        end

        // manual frames with the sink always ready
        for (int i = 0; i < 8; i++) begin
            override = 1'($urandom % 2);
            start    = 1'b1;
            receive_frame(1'b0);
            repeat (3) advance();
        end

        // back-pressure
        ready_random = 1'b1;
        for (int i = 0; i < 8; i++) begin
            override = 1'($urandom % 2);
            start    = 1'b1;
            receive_frame(1'b0);
            repeat (2) advance();
        end
        ready_random = 1'b0;
        m_ready      = 1'b1;

        // starts during a frame
        for (int i = 0; i < 4; i++) begin
            override = 1'($urandom % 2);
            start    = 1'b1;
            receive_frame(1'b1);
            repeat (5) advance();
        end

        // periodic triggers only
        ready_random = 1'b1;
        sync_enable  = 1'b1;
        frames       = 0;
        last_start   = 0;
        prev_valid   = 1'b0;
        for (int i = 0; i < 3 * `SYNC_INTERVAL + 50; i++) begin
            if (($urandom % 16) == 0 && adjust_ready) begin
                adjust_valid = 1'b1;
                adjust_sign  = 1'($urandom % 2);
            end
            advance();
            if (m_valid && !prev_valid) begin
                if (frames > 0) begin
                    check_value("frame spacing", cycle_no - last_start, `SYNC_INTERVAL);
                end
                last_start = cycle_no;
                frames++;
            end
            prev_valid = m_valid;
        end
        check_value("interval frame count", frames, 3);

        sync_enable = 1'b0;
        repeat (30) advance();

        $display("Done: no errors");
        $finish;
    end

endmodule

/* verilog/synctimer_master.sv */
`timescale 1ns/1ps
`include "synctimer_macros.svh"

module synctimer_master (
    input  logic                      clk,
    input  logic                      reset,

    input  synctimer_pkg::sync_time_t set_time,
    input  logic                      set_valid,
    input  logic                      adjust_sign,
    input  logic                      adjust_valid,
    output logic                      adjust_ready,
    output synctimer_pkg::sync_time_t current_time,

    input  logic                      start,
    input  logic                      override,
    input  logic                      sync_enable,

    output synctimer_pkg::sync_byte_t m_stream,
    output logic                      m_valid,
    input  logic                      m_ready
);

    import synctimer_pkg::*;

    logic        interval_tick;
    logic        trigger;
    logic        load;
    logic        shift;
    logic        frame_last;
    logic [7:0]  frame_data;
    sync_frame_t frame;

    assign trigger = start || interval_tick;

    // snapshot source, captured by the shifter on load
    assign frame.node_id    = `SYNC_NODE_ID;
    assign frame.cmd        = override ? cmd_override : cmd_correct;
    assign frame.time_value = current_time;
    assign frame.offset     = `SYNC_OFFSET;

    assign m_stream = '{data: frame_data, last: frame_last};

    synctimer_timer #(
        .NUMERATOR   (`SYNC_NUMERATOR),
        .DENOMINATOR (`SYNC_DENOMINATOR)
    ) u_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     (set_time),
        .set_valid    (set_valid),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready),
        .current_time (current_time)
    );

    sync_interval_counter #(
        .PERIOD (`SYNC_INTERVAL)
    ) u_interval (
        .clk    (clk),
        .reset  (reset),
        .enable (sync_enable),
        .tick   (interval_tick)
    );

    sync_frame_fsm u_fsm (
        .clk     (clk),
        .reset   (reset),
        .trigger (trigger),
        .m_ready (m_ready),
        .load    (load),
        .shift   (shift),
        .m_valid (m_valid),
        .m_last  (frame_last)
    );

    sync_frame_shifter u_shifter (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .shift (shift),
        .frame (frame),
        .data  (frame_data)
    );

endmodule

/* verilog/sync_frame_shifter.sv */
`timescale 1ns/1ps

module sync_frame_shifter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       load,
    input  logic                       shift,
    input  synctimer_pkg::sync_frame_t frame,
    output logic [7:0]                 data
);

    import synctimer_pkg::*;

    localparam int unsigned NUM_BYTES = $bits(sync_frame_t) / 8;

    // byte 0 is the one on the wire
    logic [NUM_BYTES-1:0][7:0] buffer;

    always_ff @(posedge clk) begin
        if (reset) begin
            buffer <= '0;
        end else if (load) begin
            buffer[0]    <= frame.node_id;
            buffer[1]    <= frame.cmd;
            buffer[9:2]  <= frame.time_value; // lsb lands in byte 2
            buffer[11:10] <= frame.offset;
        end else if (shift) begin
            buffer <= {8'h00, buffer[NUM_BYTES-1:1]};
        end
    end

    assign data = buffer[0];

endmodule

/* verilog/sync_frame_fsm.sv */
`timescale 1ns/1ps
`include "synctimer_macros.svh"

module sync_frame_fsm (
    input  logic clk,
    input  logic reset,
    input  logic trigger,
    input  logic m_ready,
    output logic load,
    output logic shift,
    output logic m_valid,
    output logic m_last
);

    import synctimer_pkg::*;

    localparam int unsigned CNT_W = $clog2(`SYNC_FRAME_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`SYNC_FRAME_BYTES - 1);

    frame_state_e     state;
    logic [CNT_W-1:0] byte_cnt;

    // triggers outside idle are ignored
    assign load    = (state == st_idle) && trigger;
    assign m_valid = (state == st_send);
    assign shift   = m_valid && m_ready; // one byte accepted
    assign m_last  = m_valid && (byte_cnt == LAST_BYTE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    byte_cnt <= '0;
                    if (load) begin
                        state <= st_send;
                    end
                end
                st_send: begin
                    if (shift) begin
                        if (m_last) begin
                            state    <= st_idle;
                            byte_cnt <= '0;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state    <= st_idle;
                    byte_cnt <= '0;
                end
            endcase
        end
    end

endmodule

/* verilog/sync_interval_counter.sv */
`timescale 1ns/1ps

module sync_interval_counter #(
    parameter int unsigned PERIOD = 200
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    output logic tick
);

    localparam int unsigned CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_W'(PERIOD - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!enable) begin
            count <= '0; // hold while disabled
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // registered, first pulse lands PERIOD cycles after enable
    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= enable && wrap;
        end
    end

endmodule

/* verilog/synctimer_timer.sv */
`timescale 1ns/1ps

module synctimer_timer #(
    parameter int unsigned NUMERATOR   = 10,
    parameter int unsigned DENOMINATOR = 3
) (
    input  logic                      clk,
    input  logic                      reset,

    input  synctimer_pkg::sync_time_t set_time,
    input  logic                      set_valid,

    input  logic                      adjust_sign, // high means subtract
    input  logic                      adjust_valid,
    output logic                      adjust_ready,

    output synctimer_pkg::sync_time_t current_time
);

    import synctimer_pkg::*;

    // remainder needs room for rem + frac before the wrap
    localparam int unsigned REM_W = $clog2(DENOMINATOR) + 1;
    localparam sync_time_t  STEP  = sync_time_t'(NUMERATOR / DENOMINATOR);
    localparam int unsigned FRAC  = NUMERATOR % DENOMINATOR;

    logic [REM_W-1:0] rem;
    logic [REM_W-1:0] rem_sum;
    logic [REM_W-1:0] rem_next;
    logic             carry;
    logic             adjust_accept;
    sync_time_t       time_next;

    // set has priority, the adjust is not taken then
    assign adjust_accept = adjust_valid && adjust_ready && !set_valid;

    always_comb begin
        rem_sum = rem + REM_W'(FRAC);
        carry   = (rem_sum >= REM_W'(DENOMINATOR));
        if (carry) begin
            rem_next = rem_sum - REM_W'(DENOMINATOR);
        end else begin
            rem_next = rem_sum;
        end
    end

    always_comb begin
        time_next = current_time + STEP + sync_time_t'(carry);
        if (adjust_accept) begin
            if (adjust_sign) begin
                time_next = time_next - sync_time_t'(1);
            end else begin
                time_next = time_next + sync_time_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            rem          <= '0;
        end else if (set_valid) begin
            current_time <= set_time;
            rem          <= '0; // restart the fraction
        end else begin
            current_time <= time_next;
            rem          <= rem_next;
        end
    end

    // one adjust every two cycles at most
    always_ff @(posedge clk) begin
        if (reset) begin
            adjust_ready <= 1'b1;
        end else begin
            adjust_ready <= !adjust_accept;
        end
    end

endmodule

/* verilog/synctimer_pkg.sv */
`include "synctimer_macros.svh"

package synctimer_pkg;

    // time in ns
    typedef logic [`SYNC_TIMER_WIDTH-1:0] sync_time_t;

    typedef enum logic [7:0] {
        cmd_override = 8'h10,
        cmd_correct  = 8'h11
    } sync_cmd_e;

    // fields in wire order, node id goes out first
    typedef struct packed {
        logic [7:0] node_id;
        sync_cmd_e  cmd;
        sync_time_t time_value; // sent lsb first
        logic [15:0] offset;    // low byte first
    } sync_frame_t;

    // one beat of the byte stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } sync_byte_t;

    typedef enum logic {
        st_idle,
        st_send
    } frame_state_e;

endpackage

/* verilog/synctimer_macros.svh */
`ifndef SYNCTIMER_MACROS_SVH
`define SYNCTIMER_MACROS_SVH

// time counter
`define SYNC_TIMER_WIDTH 64
`define SYNC_NUMERATOR   10 // ns per clock is NUMERATOR/DENOMINATOR
`define SYNC_DENOMINATOR 3

// sync frame layout
`define SYNC_FRAME_BYTES 12
`define SYNC_NODE_ID     8'h00
`define SYNC_OFFSET      16'h1234

// periodic trigger, in clocks
`define SYNC_INTERVAL    200

`endif
